//--- source/cpu_types_pkg.sv
// data word type, cache address field split and datapath request/response structs
package cpu_types_pkg;

	parameter int WORD_W = 32;

	// address field widths for the data cache
	parameter int DTAG_W = 26;
	parameter int DIDX_W = 3;
	parameter int DBLK_W = 1;
	parameter int DBYT_W = 2;

	typedef logic [WORD_W-1:0] word_t;

	// byte address as seen by the data cache
	typedef struct packed {
		logic [DTAG_W-1:0] tag;
		logic [DIDX_W-1:0] idx;
		logic [DBLK_W-1:0] blkoff;	// word within block
		logic [DBYT_W-1:0] bytoff;
	} dcachef_t;

	// datapath side request, held until hit
	typedef struct packed {
		logic  ren;
		logic  wen;
		logic  halt;	// flush and stop
		word_t addr;
		word_t store;
	} dcache_req_t;

	// datapath side response
	typedef struct packed {
		logic  hit;
		logic  flushed;
		word_t load;
	} dcache_rsp_t;

endpackage

//--- source/mem_bus_pkg.sv
// cache to controller bus structs and controller to RAM four-phase structs
package mem_bus_pkg;
	import cpu_types_pkg::*;

	// level request from the cache, one word at a time
	typedef struct packed {
		logic  ren;
		logic  wen;
		word_t addr;
		word_t store;
	} mem_req_t;

	typedef struct packed {
		logic  dwait;	// low for one cycle when the word is done
		word_t load;
	} mem_rsp_t;

	// four-phase request towards the RAM
	typedef struct packed {
		logic  req;
		logic  wen;
		word_t addr;
		word_t store;
	} ram_req_t;

	typedef struct packed {
		logic  ack;
		word_t load;
	} ram_rsp_t;

endpackage

//--- source/dcache.sv
// two-way set-associative write-back data cache with LRU, miss, writeback and flush FSM
module dcache import cpu_types_pkg::*, mem_bus_pkg::*; (
	input  logic        CLK,
	input  logic        nRST,
	input  dcache_req_t dreq,
	output dcache_rsp_t drsp,
	output mem_req_t    mreq,
	input  mem_rsp_t    mrsp,
	output word_t       hit_count
);
	localparam int SETS = 1 << DIDX_W;

	typedef enum logic [3:0] {
		RESET, IDLE, WRITEBACK1, WRITEBACK2, FETCH1, FETCH2, FETCH2DONE,
		FLUSH1, FLUSH2, FLUSHED
	} state_t;

	typedef struct packed {
		logic [DTAG_W-1:0]              tag;
		word_t [(1 << DBLK_W)-1:0]      data;
	} block_t;

	typedef struct packed {
		logic valid;
		logic dirty;
	} flags_t;

	state_t state, nstate;

	block_t blk_q [SETS][2];
	flags_t flags_q [SETS][2];
	logic [SETS-1:0] lru_q;	// way used last in each set
	logic vway_q;	// way being replaced by the current miss
	logic [DIDX_W:0] flush_ptr, flush_ptr_n;	// {way, set}

	dcachef_t daddr;
	logic [1:0] way_hit;
	logic req, req_hit, hit_way;
	logic victim, victim_dirty, sel_way;
	block_t vblk;
	logic [DIDX_W-1:0] fl_set;
	logic fl_way;
	block_t fl_blk;
	logic fl_dirty;

	// rebuild a block address from its fields
	function automatic word_t blk_addr(logic [DTAG_W-1:0] tag, logic [DIDX_W-1:0] idx,
			logic [DBLK_W-1:0] off);
		dcachef_t a;
		a.tag = tag;
		a.idx = idx;
		a.blkoff = off;
		a.bytoff = '0;
		return a;
	endfunction

	assign daddr = dcachef_t'(dreq.addr);
	assign req = dreq.ren | dreq.wen;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			way_hit[w] = flags_q[daddr.idx][w].valid && (blk_q[daddr.idx][w].tag == daddr.tag);
		end
	end

	assign req_hit = req && (|way_hit);
	assign hit_way = way_hit[1];

	// invalid way 0 first, then invalid way 1, then the one not used last
	assign victim = !flags_q[daddr.idx][0].valid ? 1'b0 :
			!flags_q[daddr.idx][1].valid ? 1'b1 : ~lru_q[daddr.idx];
	assign victim_dirty = flags_q[daddr.idx][victim].valid && flags_q[daddr.idx][victim].dirty;
	assign vblk = blk_q[daddr.idx][vway_q];
	assign sel_way = (state == FETCH2DONE) ? vway_q : hit_way;

	assign fl_set = flush_ptr[DIDX_W-1:0];
	assign fl_way = flush_ptr[DIDX_W];
	assign fl_blk = blk_q[fl_set][fl_way];
	assign fl_dirty = flags_q[fl_set][fl_way].valid && flags_q[fl_set][fl_way].dirty;

	// datapath response
	assign drsp.hit = (state == IDLE && !dreq.halt && req_hit) || (state == FETCH2DONE);
	assign drsp.flushed = (state == FLUSHED);
	assign drsp.load = blk_q[daddr.idx][sel_way].data[daddr.blkoff];

	always_comb begin
		nstate = state;
		flush_ptr_n = flush_ptr;
		case (state)
			RESET: nstate = IDLE;
			IDLE: begin
				if (dreq.halt) begin
					nstate = FLUSH1;
					flush_ptr_n = '0;
				end else if (req && !req_hit) begin
					nstate = victim_dirty ? WRITEBACK1 : FETCH1;
				end
			end
			WRITEBACK1: if (!mrsp.dwait) nstate = WRITEBACK2;
			WRITEBACK2: if (!mrsp.dwait) nstate = FETCH1;
			FETCH1: if (!mrsp.dwait) nstate = FETCH2;
			FETCH2: if (!mrsp.dwait) nstate = FETCH2DONE;
			FETCH2DONE: nstate = IDLE;
			FLUSH1: begin
				if (!fl_dirty) begin	// skip a clean slot
					if (flush_ptr == '1) begin
						nstate = FLUSHED;
					end else begin
						flush_ptr_n = flush_ptr + 1'b1;
					end
				end else if (!mrsp.dwait) begin
					nstate = FLUSH2;
				end
			end
			FLUSH2: begin
				if (!mrsp.dwait) begin
					if (flush_ptr == '1) begin
						nstate = FLUSHED;
					end else begin
						nstate = FLUSH1;
						flush_ptr_n = flush_ptr + 1'b1;
					end
				end
			end
			FLUSHED: if (!dreq.halt) nstate = IDLE;
			default: nstate = IDLE;
		endcase
	end

	// memory side request
	always_comb begin
		mreq = '0;
		mreq.addr = dreq.addr;
		case (state)
			WRITEBACK1: begin
				mreq.wen = 1'b1;
				mreq.addr = blk_addr(vblk.tag, daddr.idx, 1'b0);
				mreq.store = vblk.data[0];
			end
			WRITEBACK2: begin
				mreq.wen = 1'b1;
				mreq.addr = blk_addr(vblk.tag, daddr.idx, 1'b1);
				mreq.store = vblk.data[1];
			end
			FETCH1: begin
				mreq.ren = 1'b1;
				mreq.addr = blk_addr(daddr.tag, daddr.idx, 1'b0);
			end
			FETCH2: begin
				mreq.ren = 1'b1;
				mreq.addr = blk_addr(daddr.tag, daddr.idx, 1'b1);
			end
			FLUSH1: begin
				mreq.wen = fl_dirty;
				mreq.addr = blk_addr(fl_blk.tag, fl_set, 1'b0);
				mreq.store = fl_blk.data[0];
			end
			FLUSH2: begin
				mreq.wen = 1'b1;
				mreq.addr = blk_addr(fl_blk.tag, fl_set, 1'b1);
				mreq.store = fl_blk.data[1];
			end
			default: ;
		endcase
	end

	// control state, flags and counters
	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= RESET;
			flush_ptr <= '0;
			vway_q <= 1'b0;
			lru_q <= '0;
			hit_count <= '0;
			for (int s = 0; s < SETS; s++) begin
				flags_q[s][0] <= '0;
				flags_q[s][1] <= '0;
			end
		end else begin
			state <= nstate;
			flush_ptr <= flush_ptr_n;
			case (state)
				IDLE: begin
					if (!dreq.halt && req_hit) begin
						hit_count <= hit_count + 32'd1;
						lru_q[daddr.idx] <= hit_way;
						if (dreq.wen) begin
							flags_q[daddr.idx][hit_way].dirty <= 1'b1;
						end
					end else if (!dreq.halt && req) begin
						vway_q <= victim;	// held for the whole miss
					end
				end
				FETCH2DONE: begin
					flags_q[daddr.idx][vway_q].valid <= 1'b1;
					flags_q[daddr.idx][vway_q].dirty <= dreq.wen;	// write miss merges here
					lru_q[daddr.idx] <= vway_q;
				end
				FLUSHED: begin
					if (!dreq.halt) begin	// restart empty
						lru_q <= '0;
						for (int s = 0; s < SETS; s++) begin
							flags_q[s][0] <= '0;
							flags_q[s][1] <= '0;
						end
					end
				end
				default: ;
			endcase
		end
	end

	// tag and data arrays
	always_ff @(posedge CLK) begin
		case (state)
			IDLE: begin
				if (!dreq.halt && req_hit && dreq.wen) begin
					blk_q[daddr.idx][hit_way].data[daddr.blkoff] <= dreq.store;
				end
			end
			FETCH1: begin
				if (!mrsp.dwait) begin
					blk_q[daddr.idx][vway_q].tag <= daddr.tag;
					blk_q[daddr.idx][vway_q].data[0] <= mrsp.load;
				end
			end
			FETCH2: begin
				if (!mrsp.dwait) blk_q[daddr.idx][vway_q].data[1] <= mrsp.load;
			end
			FETCH2DONE: begin
				if (dreq.wen) blk_q[daddr.idx][vway_q].data[daddr.blkoff] <= dreq.store;
			end
			default: ;
		endcase
	end

endmodule

//--- source/memory_control.sv
// bus controller turning cache level requests into four-phase RAM transactions
module memory_control import mem_bus_pkg::*; (
	input  logic     CLK,
	input  logic     nRST,
	input  mem_req_t mreq,
	input  ram_rsp_t rrsp,
	output mem_rsp_t mrsp,
	output ram_req_t rreq
);
	typedef enum logic [1:0] {IDLE, REQUEST, RELEASE, DONE} state_t;

	state_t state, nstate;
	ram_rsp_t held_q;	// RAM response captured at ack
	logic active;

	assign active = mreq.ren | mreq.wen;

	always_comb begin
		nstate = state;
		case (state)
			IDLE: if (active) nstate = REQUEST;
			REQUEST: if (rrsp.ack) nstate = RELEASE;
			RELEASE: nstate = DONE;
			DONE: begin
				// ack must be low before the next word goes out
				if (!rrsp.ack) nstate = active ? REQUEST : IDLE;
			end
			default: nstate = IDLE;
		endcase
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= nstate;
		end
	end

	always_ff @(posedge CLK) begin
		if (state == REQUEST && rrsp.ack) held_q <= rrsp;
	end

	// req goes up early from idle/done so a word takes RAM_LAT+2 cycles
	assign rreq.req = (state == REQUEST) ||
			((state == IDLE || state == DONE) && active && !rrsp.ack);
	assign rreq.wen = mreq.wen;
	assign rreq.addr = mreq.addr;
	assign rreq.store = mreq.store;

	assign mrsp.dwait = active && (state != RELEASE);	// one low cycle per word
	assign mrsp.load = held_q.load;

endmodule

//--- source/ram.sv
// word-addressed RAM with reset contents and a fixed req to ack delay
module ram import cpu_types_pkg::*, mem_bus_pkg::*; #(
	parameter int RAM_LAT   = 2,
	parameter int RAM_WORDS = 256
) (
	input  logic     CLK,
	input  logic     nRST,
	input  ram_req_t rreq,
	output ram_rsp_t rrsp
);
	localparam int AW = $clog2(RAM_WORDS);
	localparam int CW = $clog2(RAM_LAT + 1);

	word_t mem [RAM_WORDS];
	logic [CW-1:0] cnt;	// cycles since req rose
	logic ack;
	word_t load_q;
	logic [AW-1:0] widx;
	logic fire;

	assign widx = rreq.addr[AW+1:2];
	assign fire = rreq.req && !ack && (cnt == CW'(RAM_LAT - 1));

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			ack <= 1'b0;
			cnt <= '0;
			// each word holds its own byte address with a marker in the top half
			for (int i = 0; i < RAM_WORDS; i++) begin
				mem[i] <= word_t'(i << 2) ^ 32'hA5A5_0000;
			end
		end else if (!rreq.req) begin
			ack <= 1'b0;	// req dropped, close the handshake
			cnt <= '0;
		end else if (fire) begin
			ack <= 1'b1;
			if (rreq.wen) mem[widx] <= rreq.store;	// write lands with ack
		end else if (!ack) begin
			cnt <= cnt + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (fire) load_q <= mem[widx];
	end

	assign rrsp.ack = ack;
	assign rrsp.load = load_q;

endmodule

//--- source/memory_system.sv
// top level chaining the data cache, bus controller and RAM
module memory_system import cpu_types_pkg::*, mem_bus_pkg::*; #(
	parameter int RAM_LAT   = 2,
	parameter int RAM_WORDS = 256
) (
	input  logic        CLK,
	input  logic        nRST,
	input  dcache_req_t dreq,
	output dcache_rsp_t drsp,
	output word_t       hit_count
);
	mem_req_t mreq;
	mem_rsp_t mrsp;
	ram_req_t rreq;
	ram_rsp_t rrsp;

	dcache u_dcache (
		.CLK       (CLK),
		.nRST      (nRST),
		.dreq      (dreq),
		.drsp      (drsp),
		.mreq      (mreq),
		.mrsp      (mrsp),
		.hit_count (hit_count)
	);

	memory_control u_memory_control (
		.CLK  (CLK),
		.nRST (nRST),
		.mreq (mreq),
		.rrsp (rrsp),
		.mrsp (mrsp),
		.rreq (rreq)
	);

	ram #(
		.RAM_LAT   (RAM_LAT),
		.RAM_WORDS (RAM_WORDS)
	) u_ram (
		.CLK  (CLK),
		.nRST (nRST),
		.rreq (rreq),
		.rrsp (rrsp)
	);

endmodule

//--- testbench/tb_memory_system.sv
// testbench for the memory system: stimulus table, shadow memory, LRU tag model and checks
module tb_memory_system import cpu_types_pkg::*; ();
	localparam int RAM_LAT = 2;
	localparam int RAM_WORDS = 256;
	localparam int SETS = 1 << DIDX_W;
	localparam logic [1:0] OP_RD = 2'd0;
	localparam logic [1:0] OP_WR = 2'd1;
	localparam logic [1:0] OP_HALT = 2'd2;

	typedef struct packed {
		logic [3:0] test;
		logic [1:0] op;
		word_t      addr;
		word_t      store;
		word_t      load;	// expected, reads only
		logic       hit;	// answer in the first cycle
		word_t      cnt;	// hit_count after the row
	} row_t;

	logic CLK, nRST;
	dcache_req_t dreq;
	dcache_rsp_t drsp;
	word_t hit_count;

	row_t rows [$];
	word_t shadow [RAM_WORDS];
	logic [DTAG_W-1:0] mtag [SETS][2];
	logic mvalid [SETS][2];
	logic mlru [SETS];	// way used last
	int exp_hits, errors, test_errors, tests, failed_tests;
	int cycles, limit;
	word_t rnd;

	memory_system #(
		.RAM_LAT   (RAM_LAT),
		.RAM_WORDS (RAM_WORDS)
	) u_dut (
		.CLK       (CLK),
		.nRST      (nRST),
		.dreq      (dreq),
		.drsp      (drsp),
		.hit_count (hit_count)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// append one row; shadow memory gives the load, the tag model gives the hit
	function automatic void add_row(input int test, input logic [1:0] op, input word_t addr,
			input word_t store);
		row_t r;
		dcachef_t f;
		int way;
		f = dcachef_t'(addr);
		r = '0;
		r.test = 4'(test);
		r.op = op;
		r.addr = addr;
		r.store = store;
		way = -1;
		for (int s = 0; s < SETS; s++) begin
			for (int w = 0; w < 2; w++) begin
				if (op == OP_HALT) mvalid[s][w] = 1'b0;	// halt empties the cache
				else if (s == int'(f.idx) && mvalid[s][w] && mtag[s][w] == f.tag) way = w;
			end
			if (op == OP_HALT) mlru[s] = 1'b0;
		end
		if (op != OP_HALT) begin
			r.hit = (way >= 0);
			if (way >= 0) begin
				exp_hits++;
			end else begin
				way = !mvalid[f.idx][0] ? 0 : !mvalid[f.idx][1] ? 1 : int'(!mlru[f.idx]);
				mvalid[f.idx][way] = 1'b1;
				mtag[f.idx][way] = f.tag;
			end
			mlru[f.idx] = way[0];
			if (op == OP_WR) shadow[addr[9:2]] = store;
			r.load = shadow[addr[9:2]];
		end
		r.cnt = word_t'(exp_hits);
		rows.push_back(r);
	endfunction

	// hold the request until hit, then check latency and load
	task automatic run_access(input row_t r);
		int waited;
		word_t got;
		waited = 0;
		@(negedge CLK);
		dreq.ren = (r.op == OP_RD);
		dreq.wen = (r.op == OP_WR);
		dreq.addr = r.addr;
		dreq.store = r.store;
		#2;
		while (!drsp.hit) begin
			@(negedge CLK);
			waited++;
			#2;
		end
		got = drsp.load;
		assert ((waited == 0) == r.hit) else begin
			$display("ERROR %0t: drsp.hit in first cycle at %h = %0b, expected %0b",
					$time, r.addr, waited == 0, r.hit);
			test_errors++;
		end
		if (r.op == OP_RD) begin
			assert (got == r.load) else begin
				$display("ERROR %0t: drsp.load at %h = %h, expected %h",
						$time, r.addr, got, r.load);
				test_errors++;
			end
		end
		@(negedge CLK);
		dreq = '0;
	endtask

	task automatic run_flush();
		@(negedge CLK);
		dreq = '0;
		dreq.halt = 1'b1;
		#2;
		while (!drsp.flushed) begin
			@(negedge CLK);
			#2;
		end
		@(negedge CLK);
		assert (drsp.flushed) else begin
			$display("flush error: flushed dropped while halt was still held");
			test_errors++;
		end
		dreq.halt = 1'b0;	// cache restarts empty
	endtask

	initial begin
		void'($urandom(32'h3a12));
		nRST = 1'b0;
		dreq = '0;
		limit = 0;
		exp_hits = 0;
		for (int i = 0; i < RAM_WORDS; i++) begin
			shadow[i] = word_t'(i * 4) ^ 32'hA5A5_0000;
		end
		add_row(0, OP_HALT, '0, '0);	// only clears the model
		rows.delete();
		add_row(1, OP_RD, 32'h040, '0);
		add_row(1, OP_RD, 32'h044, '0);
		add_row(2, OP_WR, 32'h044, 32'hCAFE_0001);
		add_row(2, OP_RD, 32'h044, '0);
		add_row(3, OP_RD, 32'h080, '0);	// tags 2 and 3 push out dirty tag 1
		add_row(3, OP_RD, 32'h0C0, '0);
		add_row(3, OP_RD, 32'h044, '0);
		for (int i = 0; i < 20; i++) begin
			rnd = $urandom;
			// four tags over sets 2 and 3
			add_row(4, rnd[4] ? OP_WR : OP_RD,
					{24'd0, rnd[1:0], 2'b01, rnd[2], rnd[3], 2'b00}, $urandom);
		end
		add_row(5, OP_WR, 32'h2D0, 32'h5EED_0005);
		add_row(5, OP_HALT, '0, '0);
		add_row(5, OP_RD, 32'h044, '0);
		add_row(5, OP_RD, 32'h2D0, '0);
		limit = rows.size() * 4 * (RAM_LAT + 4) + 32 * (RAM_LAT + 4);

		repeat (2) @(negedge CLK);
		nRST = 1'b1;
		for (int i = 0; i < rows.size(); i++) begin
			if (rows[i].op == OP_HALT) run_flush();
			else run_access(rows[i]);
			if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
				assert (hit_count == rows[i].cnt) else begin
					$display("ERROR %0t: hit_count = %0d, expected %0d",
							$time, hit_count, rows[i].cnt);
					test_errors++;
				end
				$display("test %0d: %0s (%0d errors)", rows[i].test,
						test_errors == 0 ? "ok" : "failed", test_errors);
				tests++;
				if (test_errors != 0) failed_tests++;
				errors += test_errors;
				test_errors = 0;
			end
		end
		$display("summary: %0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge CLK);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", limit);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- flist.f
source/cpu_types_pkg.sv
source/mem_bus_pkg.sv
source/dcache.sv
source/memory_control.sv
source/ram.sv
source/memory_system.sv
testbench/tb_memory_system.sv

//--- run_sim.sh
#!/usr/bin/env bash
# compile with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

if ! verilator --binary --timing --assert -j 0 -f flist.f \
	--top-module tb_memory_system -Mdir obj_dir; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vtb_memory_system > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
